// File: bench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_tb
  import rob_pkg::*;
();

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic                  done;
    rob_entry_t            e;
  } model_entry_t;

  logic                   clk;
  logic                   rst;
  logic                   dispatch_valid;
  rob_dispatch_t          dispatch;
  logic                   dispatch_ready;
  logic [`ROB_TAG_W-1:0]  dispatch_tag;
  logic                   complete_valid;
  rob_complete_t          complete;
  logic                   retire;
  logic                   exc_valid;
  exc_report_t            exc_report;
  logic [`REG_ADDR_W-1:0] rd_addr_a;
  logic [`REG_ADDR_W-1:0] rd_addr_b;
  logic [`DATA_W-1:0]     rd_data_a;
  logic [`DATA_W-1:0]     rd_data_b;

  integer             seed;
  int                 errors;
  int                 checks;
  int                 tests;
  int                 tail_count;
  int                 head_count;
  int                 retire_count;
  int                 disp_count;
  int                 exc_model;
  int                 exc_seen;
  bit                 flushing_m;
  bit                 exc_pending;
  exc_report_t        exc_exp;
  model_entry_t       q [$];
  logic [`DATA_W-1:0] regs_m [`REG_COUNT];

  rob_top rob_top_inst (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag   (dispatch_tag),
    .complete_valid (complete_valid),
    .complete       (complete),
    .retire         (retire),
    .exc_valid      (exc_valid),
    .exc_report     (exc_report),
    .rd_addr_a      (rd_addr_a),
    .rd_addr_b      (rd_addr_b),
    .rd_data_a      (rd_data_a),
    .rd_data_b      (rd_data_b)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic bit roll(input int pct);
    logic [31:0] w;
    w = $random(seed);
    return (w[30:0] % 100) < pct;
  endfunction

  function automatic exc_code_e rand_exc();
    logic [15:0] c;
    c = rand_word() % 16'd6;
    return exc_code_e'(c[3:0] + 4'd1);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // one clock of stimulus plus the model step for it
  task automatic run_cycle(input int disp_pct, input int cpl_pct, input int exc_pct);
    int           pending [$];
    int           pick;
    bit           exp_commit;
    bit           exp_flush;
    bit           did_disp;
    logic [31:0]  w;
    model_entry_t m;
    model_entry_t front;
    @(posedge clk);
    #2;
    complete_valid = 1'b0;
    dispatch_valid = 1'b0;
    did_disp = 1'b0;
    for (int i = 0; i < q.size(); i++) begin
      if (!q[i].done) begin
        pending.push_back(i);
      end
    end
    if (pending.size() > 0 && roll(cpl_pct)) begin
      w = rand_word();
      pick = pending[w[15:0] % pending.size()];
      m = q[pick];
      complete.tag = m.tag;
      complete.data = rand_word();
      complete.exc = roll(exc_pct) ? rand_exc() : EXC_NONE;
      complete_valid = 1'b1;
      m.done = 1'b1;
      m.e.data = complete.data;
      // a dispatch exception is kept
      if (m.e.exc == EXC_NONE) begin
        m.e.exc = complete.exc;
      end
      q[pick] = m;
    end
    exp_commit = !flushing_m && q.size() > 0 && q[0].done;
    exp_flush = exp_commit && (q[0].e.exc != EXC_NONE);
    #1;
    check_value("dispatch_ready", dispatch_ready,
                !flushing_m && !exp_flush && q.size() < `ROB_DEPTH);
    if (dispatch_ready && roll(disp_pct)) begin
      w = rand_word();
      dispatch.reg_write_en = roll(80);
      dispatch.reg_addr = w[4:0];
      dispatch.exc = roll(exc_pct) ? rand_exc() : EXC_NONE;
      dispatch.is_delayslot = roll(20);
      w = rand_word();
      dispatch.pc = {w[31:2], 2'b00};
      dispatch_valid = 1'b1;
      did_disp = 1'b1;
      check_value("dispatch_tag", dispatch_tag, tail_count % `ROB_DEPTH);
      m = '0;
      m.tag = tail_count % `ROB_DEPTH;
      m.e.reg_write_en = dispatch.reg_write_en;
      m.e.reg_addr = dispatch.reg_addr;
      m.e.exc = dispatch.exc;
      m.e.is_delayslot = dispatch.is_delayslot;
      m.e.pc = dispatch.pc;
    end
    // sample at the falling edge
    #17;
    check_value("exc_valid", exc_valid, exc_pending);
    if (exc_pending) begin
      check_value("exc_report.code", exc_report.code, exc_exp.code);
      check_value("exc_report.epc", exc_report.epc, exc_exp.epc);
    end
    if (exc_valid) begin
      exc_seen++;
    end
    if (retire) begin
      retire_count++;
    end
    check_value("retire", retire, exp_commit);
    exc_pending = exp_flush;
    if (exp_commit) begin
      front = q.pop_front();
      head_count++;
      if (front.e.exc == EXC_NONE && front.e.reg_write_en && front.e.reg_addr != 0) begin
        regs_m[front.e.reg_addr] = front.e.data;
      end
      if (exp_flush) begin
        exc_exp.code = front.e.exc;
        // delay slot entries report the branch
        exc_exp.epc = front.e.is_delayslot ? front.e.pc - 32'd4 : front.e.pc;
        exc_model++;
        q.delete();
        tail_count = head_count;
      end
    end
    if (did_disp) begin
      q.push_back(m);
      tail_count++;
      disp_count++;
    end
    flushing_m = exp_flush;
  endtask

  task automatic drain(input string what);
    int n;
    n = 0;
    while ((q.size() > 0 || flushing_m || exc_pending) && n < 200) begin
      run_cycle(0, 100, 0);
      n++;
    end
    if (q.size() > 0 || flushing_m || exc_pending) begin
      errors++;
      $display("timeout: the buffer did not drain in %s", what);
    end
  endtask

  task automatic check_regs();
    @(posedge clk);
    #2;
    dispatch_valid = 1'b0;
    complete_valid = 1'b0;
    for (int i = 0; i < 16; i++) begin
      rd_addr_a = i[4:0];
      rd_addr_b = 5'd16 + i[4:0];
      #1;
      check_value($sformatf("rd_data_a r%0d", i), rd_data_a, regs_m[i]);
      check_value($sformatf("rd_data_b r%0d", i + 16), rd_data_b, regs_m[i + 16]);
    end
  endtask

  task automatic end_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - start);
    end
  endtask

  initial begin
    int start;
    int n;
    int r0;
    int d0;
    int x0;
    seed = 90;
    rst = 1'b0;
    dispatch_valid = 1'b0;
    dispatch = '0;
    complete_valid = 1'b0;
    complete = '0;
    rd_addr_a = '0;
    rd_addr_b = '0;
    errors = 0;
    checks = 0;
    tests = 0;
    tail_count = 0;
    head_count = 0;
    retire_count = 0;
    disp_count = 0;
    exc_model = 0;
    exc_seen = 0;
    flushing_m = 1'b0;
    exc_pending = 1'b0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      regs_m[i] = '0;
    end
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b1;
    #1;
    start = errors;
    check_value("dispatch_ready", dispatch_ready, 1);
    check_value("dispatch_tag", dispatch_tag, 0);
    check_value("retire", retire, 0);
    check_value("exc_valid", exc_valid, 0);
    end_test("reset", start);

    // fill with no completions
    start = errors;
    r0 = retire_count;
    d0 = disp_count;
    n = 0;
    while (q.size() < `ROB_DEPTH && n < 50) begin
      run_cycle(100, 0, 0);
      n++;
    end
    if (q.size() < `ROB_DEPTH) begin
      errors++;
      $display("timeout: the buffer never filled");
    end
    run_cycle(100, 0, 0);
    check_value("dispatches to full", disp_count - d0, `ROB_DEPTH);
    check_value("retires while full", retire_count - r0, 0);
    end_test("tags and full buffer", start);

    start = errors;
    drain("in-order drain");
    check_regs();
    end_test("in-order retirement", start);

    start = errors;
    repeat (6) begin
      run_cycle(100, 0, 0);
      r0 = retire_count;
      run_cycle(0, 100, 0);
      check_value("forwarded retire", retire_count - r0, 1);
    end
    check_regs();
    end_test("head forwarding", start);

    start = errors;
    x0 = exc_model;
    repeat (300) run_cycle(60, 50, 25);
    drain("exception run");
    check_regs();
    check_value("exception reports", exc_seen, exc_model);
    if (exc_model == x0) begin
      errors++;
      $display("no exception was raised in the exception test");
    end
    end_test("exceptions", start);

    start = errors;
    repeat (2000) run_cycle(50, 40, 2);
    drain("mixed run");
    check_regs();
    check_value("exception reports", exc_seen, exc_model);
    end_test("random mixed run", start);

    $display("tests %0d, checks %0d, errors %0d, retired %0d, exceptions %0d",
             tests, checks, errors, retire_count, exc_seen);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/arch_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module arch_reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   wr_en,
  input  logic [`REG_ADDR_W-1:0] wr_addr,
  input  logic [`DATA_W-1:0]     wr_data,
  input  logic [`REG_ADDR_W-1:0] rd_addr_a,
  input  logic [`REG_ADDR_W-1:0] rd_addr_b,
  output logic [`DATA_W-1:0]     rd_data_a,
  output logic [`DATA_W-1:0]     rd_data_b
);

  logic [`DATA_W-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      // r0 stays hardwired to zero
      regs[wr_addr] <= wr_data;
    end
  end

  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module reorder_buffer
  import rob_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  dispatch_valid,
  input  rob_dispatch_t         dispatch,
  output logic                  dispatch_ready,
  output logic [`ROB_TAG_W-1:0] dispatch_tag,
  input  logic                  complete_valid,
  input  rob_complete_t         complete,
  output logic                  head_valid,
  output rob_entry_t            head,
  input  logic                  commit,
  input  logic                  flush
);

  // extra msb tells full from empty
  logic [`ROB_TAG_W:0]   head_ptr;
  logic [`ROB_TAG_W:0]   tail_ptr;
  logic [`ROB_TAG_W-1:0] head_idx;
  logic [`ROB_TAG_W-1:0] tail_idx;
  logic                  empty;
  logic                  full;
  logic                  accept;
  logic                  fwd;

  logic [`ROB_DEPTH-1:0] line_write_en;
  logic [`ROB_DEPTH-1:0] line_update_en;
  logic [`ROB_DEPTH-1:0] line_done;
  rob_entry_t            line_entry [`ROB_DEPTH];
  rob_entry_t            head_line;

  logic [`ROB_TAG_W:0]   occupancy;
  logic [`ROB_TAG_W-1:0] cpl_offset;
  logic                  cpl_live;

  assign head_idx = head_ptr[`ROB_TAG_W-1:0];
  assign tail_idx = tail_ptr[`ROB_TAG_W-1:0];
  assign empty    = (head_ptr == tail_ptr);
  assign full     = (head_idx == tail_idx) && (head_ptr[`ROB_TAG_W] != tail_ptr[`ROB_TAG_W]);

  assign dispatch_ready = !full && !flush;
  assign dispatch_tag   = tail_idx;
  assign accept         = dispatch_valid && dispatch_ready;

  for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_line
    localparam logic [`ROB_TAG_W-1:0] SLOT = i;

    assign line_write_en[i]  = accept && (tail_idx == SLOT);
    assign line_update_en[i] = complete_valid && (complete.tag == SLOT);

    rob_line rob_line_inst (
      .clk         (clk),
      .rst         (rst),
      .write_en    (line_write_en[i]),
      .write_data  (dispatch),
      .update_en   (line_update_en[i]),
      .update_data (complete),
      .done        (line_done[i]),
      .entry       (line_entry[i])
    );
  end

  // head select, completion forwarded when it hits the head
  assign head_line  = line_entry[head_idx];
  assign fwd        = complete_valid && !empty && (complete.tag == head_idx);
  assign head_valid = !empty && (line_done[head_idx] || fwd);

  always_comb begin
    head = head_line;
    if (fwd) begin
      head.data = complete.data;
      if (head_line.exc == EXC_NONE) begin
        head.exc = complete.exc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_ptr <= '0;
    end else if (commit) begin
      head_ptr <= head_ptr + 1'b1;
    end
  end

  // flush drops everything behind the committing head
  always_ff @(posedge clk) begin
    if (!rst) begin
      tail_ptr <= '0;
    end else if (flush) begin
      tail_ptr <= head_ptr + 1'b1;
    end else if (accept) begin
      tail_ptr <= tail_ptr + 1'b1;
    end
  end

  assign occupancy  = tail_ptr - head_ptr;
  assign cpl_offset = complete.tag - head_idx;
  assign cpl_live   = ({1'b0, cpl_offset} < occupancy);

  a_dispatch_ready: assert property (
    @(posedge clk) disable iff (!rst) dispatch_valid |-> dispatch_ready);

  a_commit_valid: assert property (
    @(posedge clk) disable iff (!rst) commit |-> head_valid);

  // completion must target a live line that is still pending
  a_complete_live: assert property (
    @(posedge clk) disable iff (!rst)
    complete_valid |-> (cpl_live && !line_done[complete.tag]));

endmodule

`default_nettype wire

// File: hw/retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module retire_unit
  import rob_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   head_valid,
  input  rob_entry_t             head,
  output logic                   commit,
  output logic                   flush,
  output logic                   wr_en,
  output logic [`REG_ADDR_W-1:0] wr_addr,
  output logic [`DATA_W-1:0]     wr_data,
  output logic                   exc_valid,
  output exc_report_t            exc_report,
  output logic                   flushing
);

  retire_state_e state_q;
  retire_state_e state_d;
  logic          head_exc;

  assign head_exc = (head.exc != EXC_NONE);
  assign commit   = head_valid && (state_q == RETIRE_RUN);
  assign flush    = commit && head_exc;
  assign flushing = (state_q == RETIRE_FLUSH);

  // excepting entries retire without touching the register file
  assign wr_en   = commit && !head_exc && head.reg_write_en;
  assign wr_addr = head.reg_addr;
  assign wr_data = head.data;

  always_comb begin
    state_d = RETIRE_RUN;
    if (state_q == RETIRE_RUN && flush) begin
      state_d = RETIRE_FLUSH;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q   <= RETIRE_RUN;
      exc_valid <= 1'b0;
    end else begin
      state_q   <= state_d;
      exc_valid <= flush;
    end
  end

  always_ff @(posedge clk) begin
    if (flush) begin
      exc_report.code <= head.exc;
      // delay slot reports the branch pc
      exc_report.epc  <= head.is_delayslot ? head.pc - `ADDR_W'(`DELAYSLOT_PC_STEP) : head.pc;
    end
  end

  // one quiet cycle with an empty buffer follows every flush
  a_flush_seq: assert property (
    @(posedge clk) disable iff (!rst)
    flush |=> !head_valid);

endmodule

`default_nettype wire

// File: hw/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_TAG_W 3

// architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// datapath widths
`define DATA_W 32
`define ADDR_W 32

// pc step back for a delay slot entry
`define DELAYSLOT_PC_STEP 4

`endif

// File: hw/rob_line.sv
`timescale 1ns/1ps
`default_nettype none

module rob_line
  import rob_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          write_en,
  input  rob_dispatch_t write_data,
  input  logic          update_en,
  input  rob_complete_t update_data,
  output logic          done,
  output rob_entry_t    entry
);

  logic       done_q;
  rob_entry_t line_q;

  // dispatch opens the line, completion closes it
  always_ff @(posedge clk) begin
    if (!rst) begin
      done_q <= 1'b0;
    end else if (write_en) begin
      done_q <= 1'b0;
    end else if (update_en) begin
      done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      line_q.reg_write_en <= write_data.reg_write_en;
      line_q.reg_addr     <= write_data.reg_addr;
      line_q.exc          <= write_data.exc;
      line_q.is_delayslot <= write_data.is_delayslot;
      line_q.pc           <= write_data.pc;
    end else if (update_en) begin
      line_q.data <= update_data.data;
      // an earlier dispatch exception wins
      if (line_q.exc == EXC_NONE) begin
        line_q.exc <= update_data.exc;
      end
    end
  end

  assign done  = done_q;
  assign entry = line_q;

endmodule

`default_nettype wire

// File: hw/rob_pkg.sv
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

  typedef enum logic [3:0] {
    EXC_NONE           = 4'd0,
    EXC_OVERFLOW       = 4'd1,
    EXC_SYSCALL        = 4'd2,
    EXC_BREAK          = 4'd3,
    EXC_RESERVED_INSTR = 4'd4,
    EXC_ADDR_LOAD      = 4'd5,
    EXC_ADDR_STORE     = 4'd6
  } exc_code_e;

  typedef enum logic {
    RETIRE_RUN   = 1'b0,
    RETIRE_FLUSH = 1'b1
  } retire_state_e;

  typedef struct packed {
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_addr;
    exc_code_e              exc;
    logic                   is_delayslot;
    logic [`ADDR_W-1:0]     pc;
  } rob_dispatch_t;

  typedef struct packed {
    logic [`ROB_TAG_W-1:0] tag;
    logic [`DATA_W-1:0]    data;
    exc_code_e             exc;
  } rob_complete_t;

  typedef struct packed {
    logic                   reg_write_en;
    logic [`REG_ADDR_W-1:0] reg_addr;
    logic [`DATA_W-1:0]     data;
    exc_code_e              exc;
    logic                   is_delayslot;
    logic [`ADDR_W-1:0]     pc;
  } rob_entry_t;

  typedef struct packed {
    exc_code_e          code;
    logic [`ADDR_W-1:0] epc;
  } exc_report_t;

endpackage

`default_nettype wire

// File: hw/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   dispatch_valid,
  input  rob_dispatch_t          dispatch,
  output logic                   dispatch_ready,
  output logic [`ROB_TAG_W-1:0]  dispatch_tag,
  input  logic                   complete_valid,
  input  rob_complete_t          complete,
  output logic                   retire,
  output logic                   exc_valid,
  output exc_report_t            exc_report,
  input  logic [`REG_ADDR_W-1:0] rd_addr_a,
  input  logic [`REG_ADDR_W-1:0] rd_addr_b,
  output logic [`DATA_W-1:0]     rd_data_a,
  output logic [`DATA_W-1:0]     rd_data_b
);

  logic                   rob_ready;
  logic                   head_valid;
  rob_entry_t             head;
  logic                   commit;
  logic                   flush;
  logic                   flushing;
  logic                   wr_en;
  logic [`REG_ADDR_W-1:0] wr_addr;
  logic [`DATA_W-1:0]     wr_data;

  // hold dispatch off through the flush recovery cycle
  assign dispatch_ready = rob_ready && !flushing;
  assign retire         = commit;

  reorder_buffer reorder_buffer_inst (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (rob_ready),
    .dispatch_tag   (dispatch_tag),
    .complete_valid (complete_valid),
    .complete       (complete),
    .head_valid     (head_valid),
    .head           (head),
    .commit         (commit),
    .flush          (flush)
  );

  retire_unit retire_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head       (head),
    .commit     (commit),
    .flush      (flush),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .exc_valid  (exc_valid),
    .exc_report (exc_report),
    .flushing   (flushing)
  );

  arch_reg_file arch_reg_file_inst (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps --top-module rob_tb \
  -f sim.f -o rob_sim > sim.log 2>&1 &&
  ./obj_dir/rob_sim >> sim.log 2>&1 ||
  echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// File: sim.f
+incdir+hw
hw/rob_pkg.sv
hw/rob_line.sv
hw/reorder_buffer.sv
hw/retire_unit.sv
hw/arch_reg_file.sv
hw/rob_top.sv
bench/rob_tb.sv
